//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // Default register width, RV64
    localparam int XLEN_DEFAULT = 64;

    // funct3 of the M-extension ops (opcode OP, funct7 0000001)
    typedef enum logic [2:0] {
        OP_MUL    = 3'd0,
        OP_MULH   = 3'd1,
        OP_MULHSU = 3'd2,
        OP_MULHU  = 3'd3,
        OP_DIV    = 3'd4,
        OP_DIVU   = 3'd5,
        OP_REM    = 3'd6,
        OP_REMU   = 3'd7
    } muldiv_op_t;

    // Bit 2 separates the divide group from the multiply group
    function automatic logic op_is_div(muldiv_op_t op);
        return op[2];
    endfunction

    // Meaningful for the divide group only
    function automatic logic op_div_unsigned(muldiv_op_t op);
        return op[0];
    endfunction

    function automatic logic op_div_rem(muldiv_op_t op);
        return op[1];
    endfunction

endpackage

//--- logic/muldiv_pkg.sv
package muldiv_pkg;

    // Issue tag width, enough for a register index
    localparam int TAG_W = 5;

    // Destination register carried with each operation
    typedef logic [TAG_W-1:0] tag_t;

    // Which unit owns the writeback bus this cycle
    typedef enum logic {
        SRC_DIV = 1'b0,
        SRC_MUL = 1'b1
    } wb_src_t;

endpackage

//--- logic/mul_unit.sv
`timescale 1ns/100ps

module mul_unit
    import rv_isa_pkg::*;
    import muldiv_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  muldiv_op_t      op,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  tag_t            tag,
    input  logic            grant,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] result,
    output tag_t            result_tag
);

    logic mul_issue;
    logic rs1_signed;
    logic rs2_signed;

    // Stage flags for operands and product
    logic opnd_valid_q;
    logic prod_valid_q;

    logic signed [XLEN:0]     opnd_a_q;
    logic signed [XLEN:0]     opnd_b_q;
    logic                     hi_sel_q;
    logic signed [2*XLEN+1:0] prod_full;
    logic [2*XLEN-1:0]        prod_q;

    assign mul_issue  = issue && !op_is_div(op);
    assign rs1_signed = (op == OP_MULH) || (op == OP_MULHSU);
    assign rs2_signed = (op == OP_MULH);

    // One extra bit per operand lets a single signed multiply
    // cover signed, unsigned and mixed operands
    assign prod_full = opnd_a_q * opnd_b_q;

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy         <= 1'b0;
            done         <= 1'b0;
            opnd_valid_q <= 1'b0;
            prod_valid_q <= 1'b0;
        end else begin
            opnd_valid_q <= mul_issue;
            prod_valid_q <= opnd_valid_q;
            if (mul_issue) begin
                busy <= 1'b1;
            end else if (grant) begin
                busy <= 1'b0;
            end
            // Held until the arbiter takes the result
            if (prod_valid_q) begin
                done <= 1'b1;
            end else if (grant) begin
                done <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (mul_issue) begin
            opnd_a_q   <= {rs1_signed & rs1[XLEN-1], rs1};
            opnd_b_q   <= {rs2_signed & rs2[XLEN-1], rs2};
            hi_sel_q   <= (op != OP_MUL);
            result_tag <= tag;
        end
        if (opnd_valid_q) begin
            prod_q <= prod_full[2*XLEN-1:0];
        end
        // Low half for MUL, high half for the MULH family
        if (prod_valid_q) begin
            result <= hi_sel_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];
        end
    end

    // Core has to respect busy
    assert property (@(posedge clk) disable iff (reset) mul_issue |-> !busy)
        else $error("multiply issued while mul_unit is busy");

endmodule

//--- logic/div_unit.sv
`timescale 1ns/100ps

module div_unit
    import rv_isa_pkg::*;
    import muldiv_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  muldiv_op_t      op,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  tag_t            tag,
    input  logic            grant,
    output logic            busy,
    output logic            done,
    output logic [XLEN-1:0] result,
    output tag_t            result_tag
);

    localparam int CNT_W = $clog2(XLEN + 2);
    localparam logic [CNT_W-1:0] CNT_FIRST = CNT_W'(1);
    localparam logic [CNT_W-1:0] CNT_LAST  = CNT_W'(XLEN + 1);
    localparam logic [XLEN-1:0]  MOST_NEG  = {1'b1, {(XLEN-1){1'b0}}};

    logic            div_issue;
    logic            is_signed;
    logic            rs1_neg;
    logic            rs2_neg;
    logic [XLEN-1:0] rs1_abs;
    logic [XLEN-1:0] rs2_abs;
    logic            div_by_zero;
    logic            overflow;

    // Remainder in the upper half, dividend and quotient bits in the lower
    logic [2*XLEN-1:0] sr_q;
    logic [2*XLEN-1:0] sr_next;
    logic [XLEN:0]     diff;

    logic [XLEN-1:0]  divisor_q;
    logic [XLEN-1:0]  dividend_q;
    logic             neg_quo_q;
    logic             neg_rem_q;
    logic             rem_sel_q;
    logic             dbz_q;
    logic             ovf_q;
    logic [CNT_W-1:0] cnt_q;

    logic [XLEN-1:0] quo_abs;
    logic [XLEN-1:0] rem_abs;
    logic [XLEN-1:0] quo_final;
    logic [XLEN-1:0] rem_final;

    // --------------------------------------------------
    // Issue decode
    // --------------------------------------------------
    assign div_issue   = issue && op_is_div(op);
    assign is_signed   = !op_div_unsigned(op);
    assign rs1_neg     = is_signed && rs1[XLEN-1];
    assign rs2_neg     = is_signed && rs2[XLEN-1];
    assign rs1_abs     = rs1_neg ? -rs1 : rs1;
    assign rs2_abs     = rs2_neg ? -rs2 : rs2;
    assign div_by_zero = (rs2 == '0);
    assign overflow    = is_signed && (rs1 == MOST_NEG) && (rs2 == '1);

    // Restoring step, keep the shifted remainder when the subtract goes negative
    assign diff    = sr_q[2*XLEN-1:XLEN-1] - {1'b0, divisor_q};
    assign sr_next = diff[XLEN] ? {sr_q[2*XLEN-2:0], 1'b0}
                                : {diff[XLEN-1:0], sr_q[XLEN-2:0], 1'b1};

    assign quo_abs = sr_q[XLEN-1:0];
    assign rem_abs = sr_q[2*XLEN-1:XLEN];

    // Sign fix and ISA results for the early-exit cases
    always_comb begin
        if (dbz_q) begin
            quo_final = '1;
            rem_final = dividend_q;
        end else if (ovf_q) begin
            quo_final = dividend_q;
            rem_final = '0;
        end else begin
            quo_final = neg_quo_q ? -quo_abs : quo_abs;
            rem_final = neg_rem_q ? -rem_abs : rem_abs;
        end
    end

    // --------------------------------------------------
    // Control
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            cnt_q <= '0;
        end else begin
            if (div_issue) begin
                busy  <= 1'b1;
                // Special cases skip straight to the final step
                cnt_q <= (div_by_zero || overflow) ? CNT_LAST : CNT_FIRST;
            end else if (cnt_q == CNT_LAST) begin
                done  <= 1'b1;
                cnt_q <= '0;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q + CNT_FIRST;
            end
            if (grant) begin
                busy <= 1'b0;
                done <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (div_issue) begin
            sr_q       <= {{XLEN{1'b0}}, rs1_abs};
            divisor_q  <= rs2_abs;
            dividend_q <= rs1;
            neg_quo_q  <= rs1_neg ^ rs2_neg;
            neg_rem_q  <= rs1_neg;
            rem_sel_q  <= op_div_rem(op);
            dbz_q      <= div_by_zero;
            ovf_q      <= overflow;
            result_tag <= tag;
        end else if (cnt_q == CNT_LAST) begin
            result <= rem_sel_q ? rem_final : quo_final;
        end else if (cnt_q != '0) begin
            sr_q <= sr_next;
        end
    end

    assert property (@(posedge clk) disable iff (reset) div_issue |-> !busy)
        else $error("divide issued while div_unit is busy");

    assert property (@(posedge clk) disable iff (reset) cnt_q <= CNT_LAST)
        else $error("div_unit iteration counter out of range");

endmodule

//--- logic/wb_arbiter.sv
`timescale 1ns/100ps

module wb_arbiter
    import rv_isa_pkg::*;
    import muldiv_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            div_done,
    input  logic [XLEN-1:0] div_result,
    input  tag_t            div_tag,
    input  logic            mul_done,
    input  logic [XLEN-1:0] mul_result,
    input  tag_t            mul_tag,
    output logic            div_grant,
    output logic            mul_grant,
    output logic            wb_valid,
    output tag_t            wb_tag,
    output logic [XLEN-1:0] wb_data
);

    logic    any_done;
    wb_src_t sel;

    // Divider first, it always holds the older operation
    assign any_done = div_done || mul_done;
    assign sel      = div_done ? SRC_DIV : SRC_MUL;

    assign div_grant = any_done && (sel == SRC_DIV);
    assign mul_grant = any_done && (sel == SRC_MUL);

    // --------------------------------------------------
    // Writeback register, one-cycle pulse
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= any_done;
        end
    end

    always_ff @(posedge clk) begin
        if (any_done) begin
            wb_tag  <= (sel == SRC_DIV) ? div_tag : mul_tag;
            wb_data <= (sel == SRC_DIV) ? div_result : mul_result;
        end
    end

    assert property (@(posedge clk) disable iff (reset) !(div_grant && mul_grant))
        else $error("both units granted the writeback bus");

    assert property (@(posedge clk) disable iff (reset)
        (div_grant |-> div_done) and (mul_grant |-> mul_done))
        else $error("writeback grant given to a unit that is not done");

endmodule

//--- logic/muldiv_top.sv
`timescale 1ns/100ps

module muldiv_top
    import rv_isa_pkg::*;
    import muldiv_pkg::*;
#(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            issue,
    input  muldiv_op_t      op,
    input  logic [XLEN-1:0] rs1,
    input  logic [XLEN-1:0] rs2,
    input  tag_t            tag,
    output logic            mul_busy,
    output logic            div_busy,
    output logic            wb_valid,
    output tag_t            wb_tag,
    output logic [XLEN-1:0] wb_data
);

    // Unit to arbiter
    logic            div_done;
    logic [XLEN-1:0] div_result;
    tag_t            div_tag;
    logic            div_grant;
    logic            mul_done;
    logic [XLEN-1:0] mul_result;
    tag_t            mul_tag;
    logic            mul_grant;

    // --------------------------------------------------
    // Execution units, each picks its own ops
    // --------------------------------------------------
    mul_unit #(
        .XLEN (XLEN)
    ) mul_unit_i (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .op         (op),
        .rs1        (rs1),
        .rs2        (rs2),
        .tag        (tag),
        .grant      (mul_grant),
        .busy       (mul_busy),
        .done       (mul_done),
        .result     (mul_result),
        .result_tag (mul_tag)
    );

    div_unit #(
        .XLEN (XLEN)
    ) div_unit_i (
        .clk        (clk),
        .reset      (reset),
        .issue      (issue),
        .op         (op),
        .rs1        (rs1),
        .rs2        (rs2),
        .tag        (tag),
        .grant      (div_grant),
        .busy       (div_busy),
        .done       (div_done),
        .result     (div_result),
        .result_tag (div_tag)
    );

    // Shared writeback to the register file
    wb_arbiter #(
        .XLEN (XLEN)
    ) wb_arbiter_i (
        .clk        (clk),
        .reset      (reset),
        .div_done   (div_done),
        .div_result (div_result),
        .div_tag    (div_tag),
        .mul_done   (mul_done),
        .mul_result (mul_result),
        .mul_tag    (mul_tag),
        .div_grant  (div_grant),
        .mul_grant  (mul_grant),
        .wb_valid   (wb_valid),
        .wb_tag     (wb_tag),
        .wb_data    (wb_data)
    );

endmodule

//--- testbench/muldiv_tb_tasks.svh
`ifndef MULDIV_TB_TASKS_SVH
`define MULDIV_TB_TASKS_SVH

// --------------------------------------------------
// Error exit and typed compares
// --------------------------------------------------
task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopping at the first error");
endtask

task automatic check_data(input string name, input logic [XLEN-1:0] expected,
                          input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
        stop_on_error($sformatf("FAILED at %0t: %s expected %h, got %h",
                                $time, name, expected, actual));
    end
endtask

task automatic check_tag(input string name, input tag_t expected, input tag_t actual);
    if (actual !== expected) begin
        stop_on_error($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                                $time, name, expected, actual));
    end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
        stop_on_error($sformatf("FAILED at %0t: %s expected %b, got %b",
                                $time, name, expected, actual));
    end
endtask

// Cycle counts, issue edge to writeback
task automatic check_latency(input string name, input int expected, input int actual);
    if (actual != expected) begin
        stop_on_error($sformatf("FAILED at %0t: %s expected %0d, got %0d",
                                $time, name, expected, actual));
    end
endtask

// --------------------------------------------------
// Drive and wait
// --------------------------------------------------
// Called on a falling edge, returns on the one after the issue edge
task automatic issue_op(input muldiv_op_t op_in, input logic [XLEN-1:0] a,
                        input logic [XLEN-1:0] b, input tag_t tag_in);
    issue = 1'b1;
    op    = op_in;
    rs1   = a;
    rs2   = b;
    tag   = tag_in;
    @(negedge clk);
    issue = 1'b0;
endtask

task automatic wait_wb(input int max_cycles, output int cycles);
    cycles = 0;
    do begin
        @(negedge clk);
        cycles++;
        if (cycles > max_cycles) begin
            stop_on_error($sformatf("No writeback arrived within %0d cycles, time %0t",
                                    max_cycles, $time));
        end
    end while (!wb_valid);
endtask

`endif

//--- testbench/muldiv_tb.sv
`timescale 1ns/100ps

module muldiv_tb
    import rv_isa_pkg::*;
    import muldiv_pkg::*;
();

    localparam int XLEN = 64;
    localparam logic [XLEN-1:0] MIN_SIGNED = {1'b1, {(XLEN-1){1'b0}}};
    localparam logic [XLEN-1:0] ONES       = '1;

    logic            clk;
    logic            reset;
    logic            issue;
    muldiv_op_t      op;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    tag_t            tag;
    logic            mul_busy;
    logic            div_busy;
    logic            wb_valid;
    tag_t            wb_tag;
    logic [XLEN-1:0] wb_data;
    tag_t            next_tag;

    muldiv_top #(
        .XLEN (XLEN)
    ) muldiv_top_i (
        .clk      (clk),
        .reset    (reset),
        .issue    (issue),
        .op       (op),
        .rs1      (rs1),
        .rs2      (rs2),
        .tag      (tag),
        .mul_busy (mul_busy),
        .div_busy (div_busy),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_data  (wb_data)
    );

    `include "muldiv_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // --------------------------------------------------
    // Reference model from the M-extension rules
    // --------------------------------------------------
    function automatic logic [XLEN-1:0] expected_result(input muldiv_op_t op_in,
                                                        input logic [XLEN-1:0] a,
                                                        input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] s_quo;
        logic signed [XLEN-1:0] s_rem;
        logic [2*XLEN-1:0]      a_sx;
        logic [2*XLEN-1:0]      b_sx;
        logic [2*XLEN-1:0]      a_zx;
        logic [2*XLEN-1:0]      b_zx;
        logic                   ovf;
        sa   = a;
        sb   = b;
        a_sx = {{XLEN{a[XLEN-1]}}, a};
        b_sx = {{XLEN{b[XLEN-1]}}, b};
        a_zx = {{XLEN{1'b0}}, a};
        b_zx = {{XLEN{1'b0}}, b};
        ovf  = (a == MIN_SIGNED) && (b == ONES);
        // Signed quotient truncates toward zero, remainder takes the dividend's sign
        if ((b != '0) && !ovf) begin
            s_quo = sa / sb;
            s_rem = sa % sb;
        end else begin
            s_quo = '0;
            s_rem = '0;
        end
        // Products modulo 2^128 after the right extension
        case (op_in)
            OP_MUL:    return XLEN'(a_zx * b_zx);
            OP_MULH:   return (a_sx * b_sx) >> XLEN;
            OP_MULHSU: return (a_sx * b_zx) >> XLEN;
            OP_MULHU:  return (a_zx * b_zx) >> XLEN;
            OP_DIV:    return (b == '0) ? ONES : (ovf ? a : s_quo);
            OP_DIVU:   return (b == '0) ? ONES : a / b;
            OP_REM:    return (b == '0) ? a : (ovf ? '0 : s_rem);
            default:   return (b == '0) ? a : a % b;
        endcase
    endfunction

    function automatic int expected_latency(input muldiv_op_t op_in,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b);
        if (op_in inside {OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU}) begin
            return 3;
        end else if (b == '0) begin
            return 2;
        end else if ((op_in inside {OP_DIV, OP_REM}) && a == MIN_SIGNED && b == ONES) begin
            return 2;
        end
        return XLEN + 2;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [63:0] r;
        r = {$urandom(), $urandom()};
        return r[XLEN-1:0];
    endfunction

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic run_op(input muldiv_op_t op_in, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b);
        tag_t t;
        int   cycles;
        t        = next_tag;
        next_tag = next_tag + 1'b1;
        issue_op(op_in, a, b, t);
        wait_wb(XLEN + 8, cycles);
        check_latency($sformatf("%s latency", op_in.name()),
                      expected_latency(op_in, a, b), cycles);
        check_data($sformatf("wb_data (%s)", op_in.name()),
                   expected_result(op_in, a, b), wb_data);
        check_tag("wb_tag", t, wb_tag);
        check_flag("mul_busy", 1'b0, mul_busy);
        check_flag("div_busy", 1'b0, div_busy);
        // Writeback is a single-cycle pulse
        @(negedge clk);
        check_flag("wb_valid", 1'b0, wb_valid);
    endtask

    task automatic run_pair(input muldiv_op_t op_a, input muldiv_op_t op_b,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        run_op(op_a, a, b);
        run_op(op_b, a, b);
    endtask

    task automatic idle_after_reset();
        repeat (5) begin
            @(negedge clk);
            check_flag("wb_valid", 1'b0, wb_valid);
            check_flag("mul_busy", 1'b0, mul_busy);
            check_flag("div_busy", 1'b0, div_busy);
        end
    endtask

    task automatic unsigned_divides();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        run_pair(OP_DIVU, OP_REMU, XLEN'(100), XLEN'(7));
        run_pair(OP_DIVU, OP_REMU, XLEN'(7), XLEN'(100));
        run_pair(OP_DIVU, OP_REMU, ONES, XLEN'(3));
        run_pair(OP_DIVU, OP_REMU, ONES, ONES);
        run_pair(OP_DIVU, OP_REMU, MIN_SIGNED, ONES);
        run_pair(OP_DIVU, OP_REMU, XLEN'(0), XLEN'(9));
        repeat (20) begin
            a = rand_word();
            b = rand_word() >> ($urandom() % XLEN);
            run_pair(OP_DIVU, OP_REMU, a, b);
        end
    endtask

    task automatic signed_divides();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        run_pair(OP_DIV, OP_REM, XLEN'(20), XLEN'(3));
        run_pair(OP_DIV, OP_REM, XLEN'(-20), XLEN'(3));
        run_pair(OP_DIV, OP_REM, XLEN'(20), XLEN'(-3));
        run_pair(OP_DIV, OP_REM, XLEN'(-20), XLEN'(-3));
        run_pair(OP_DIV, OP_REM, MIN_SIGNED, XLEN'(7));
        run_pair(OP_DIV, OP_REM, XLEN'(-7), MIN_SIGNED);
        repeat (10) begin
            a = rand_word();
            b = rand_word() >> ($urandom() % XLEN);
            if ($urandom() % 2 != 0) begin
                b = -b;
            end
            run_pair(OP_DIV, OP_REM, a, b);
        end
    endtask

    task automatic special_divides();
        run_pair(OP_DIV, OP_DIVU, XLEN'(1234), XLEN'(0));
        run_pair(OP_REM, OP_REMU, XLEN'(-1234), XLEN'(0));
        run_pair(OP_DIV, OP_REM, MIN_SIGNED, XLEN'(0));
        run_pair(OP_DIV, OP_REM, MIN_SIGNED, ONES);
    endtask

    task automatic multiplies();
        muldiv_op_t      mul_ops [4];
        logic [XLEN-1:0] edge_vals [5];
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        mul_ops   = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
        edge_vals = '{XLEN'(0), XLEN'(1), ONES, MIN_SIGNED, ~MIN_SIGNED};
        foreach (edge_vals[i]) begin
            foreach (edge_vals[j]) begin
                foreach (mul_ops[k]) begin
                    run_op(mul_ops[k], edge_vals[i], edge_vals[j]);
                end
            end
        end
        repeat (20) begin
            a = rand_word();
            b = rand_word();
            foreach (mul_ops[k]) begin
                run_op(mul_ops[k], a, b);
            end
        end
    endtask

    task automatic overlapping_ops();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        int              cycles;
        a = rand_word();
        b = (rand_word() >> 20) | XLEN'(1);
        // Multiply overtakes a running divide
        issue_op(OP_DIV, a, b, tag_t'(10));
        repeat (3) @(negedge clk);
        check_flag("div_busy", 1'b1, div_busy);
        issue_op(OP_MULHU, a, b, tag_t'(11));
        wait_wb(8, cycles);
        check_latency("MULHU latency", 3, cycles);
        check_tag("wb_tag", tag_t'(11), wb_tag);
        check_data("wb_data (MULHU)", expected_result(OP_MULHU, a, b), wb_data);
        wait_wb(XLEN + 8, cycles);
        check_tag("wb_tag", tag_t'(10), wb_tag);
        check_data("wb_data (DIV)", expected_result(OP_DIV, a, b), wb_data);
        // Both done on the same edge and the divider wins
        issue_op(OP_REM, a, b, tag_t'(12));
        repeat (XLEN - 2) @(negedge clk);
        issue_op(OP_MUL, a, b, tag_t'(13));
        wait_wb(8, cycles);
        check_latency("REM writeback after MUL issue", 3, cycles);
        check_tag("wb_tag", tag_t'(12), wb_tag);
        check_data("wb_data (REM)", expected_result(OP_REM, a, b), wb_data);
        check_flag("div_busy", 1'b0, div_busy);
        check_flag("mul_busy", 1'b1, mul_busy);
        wait_wb(8, cycles);
        check_latency("MUL writeback after REM", 1, cycles);
        check_tag("wb_tag", tag_t'(13), wb_tag);
        check_data("wb_data (MUL)", expected_result(OP_MUL, a, b), wb_data);
        check_flag("mul_busy", 1'b0, mul_busy);
        @(negedge clk);
        check_flag("wb_valid", 1'b0, wb_valid);
    endtask

    initial begin
        void'($urandom(21));
        reset    = 1'b1;
        issue    = 1'b0;
        op       = OP_MUL;
        rs1      = '0;
        rs2      = '0;
        tag      = '0;
        next_tag = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        idle_after_reset();
        unsigned_divides();
        signed_divides();
        special_divides();
        multiplies();
        overlapping_ops();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- list.f
logic/rv_isa_pkg.sv
logic/muldiv_pkg.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/wb_arbiter.sv
logic/muldiv_top.sv
testbench/muldiv_tb.sv
+incdir+testbench

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps --top-module muldiv_tb \
    -f list.f -o muldiv_sim > sim.log 2>&1 &&
    ./obj_dir/muldiv_sim >> sim.log 2>&1 ||
    echo "TESTBENCH FAILED" >> sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed, see sim.log"
exit 0
